// File: hdl/fir_types_pkg.sv
`default_nettype none

// ***************************************************************************
// number formats of the filter datapath
// ***************************************************************************

package fir_types_pkg;

  localparam int SAMPLE_WIDTH  = 16;                 // input samples and coefficients.
  localparam int PRODUCT_WIDTH = 2 * SAMPLE_WIDTH;   // exact tap product.
  localparam int SUM_WIDTH     = PRODUCT_WIDTH + 1;  // one guard bit covers all taps.

  // two's complement input sample, also the coefficient format.
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // full precision product of one sample and one coefficient.
  typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

  // filter output.  The coefficient magnitudes add to 108340, so
  // 108340 * 32768 stays below 2**32 and the sum never wraps.
  typedef logic signed [SUM_WIDTH-1:0] sum_t;

endpackage

`default_nettype wire

// File: hdl/fir_coeff_pkg.sv
`default_nettype none

// ***************************************************************************
// tap count and the fixed coefficient table
// ***************************************************************************

package fir_coeff_pkg;

  localparam int NUM_TAPS = 8;

  // element 0 holds the newest sample.
  typedef fir_types_pkg::sample_t [NUM_TAPS-1:0] tap_vector_t;

  typedef fir_types_pkg::product_t [NUM_TAPS-1:0] product_vector_t;

  // the pattern lists tap 7 first because the range runs downward.
  // The table is symmetric, so the filter has linear phase.
  localparam tap_vector_t COEFFS = '{
    -8773, -5490, 13275, 26632,
    26632, 13275, -5490, -8773
  };

endpackage

`default_nettype wire

// File: hdl/tap_delay_line.sv
`timescale 1ns/1ns
`default_nettype none

module tap_delay_line (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          clk_enable,
  input  wire fir_types_pkg::sample_t  filter_in,
  output fir_coeff_pkg::tap_vector_t   taps
);

  localparam int NUM_TAPS = fir_coeff_pkg::NUM_TAPS;

  // ***************************************************************************
  // shift register, newest sample enters at tap 0
  // ***************************************************************************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      taps <= '0;
    end else if (clk_enable) begin
      taps <= {taps[NUM_TAPS-2:0], filter_in};  // oldest sample falls off tap 7.
    end
  end

  // a low enable freezes the whole line, not just tap 0.
  taps_hold_a : assert property (
    @(posedge clk) disable iff (reset)
    !clk_enable |=> $stable(taps)
  );

endmodule

`default_nettype wire

// File: hdl/vedic_core.sv
`timescale 1ns/1ns
`default_nettype none

// unsigned Vedic multiplier.  WIDTH must be a power of two, two or more.
module vedic_core #(
  parameter int WIDTH = 16
) (
  input  wire  [WIDTH-1:0]   a,
  input  wire  [WIDTH-1:0]   b,
  output logic [2*WIDTH-1:0] result
);

  generate
    if (WIDTH == 2) begin : g_leaf

      // ***********************************************************************
      // 2x2 block from AND terms and two half adders
      // ***********************************************************************

      logic [2:0] pp;   // cross terms and the top term.
      logic       carry;

      assign pp[0] = a[1] & b[0];
      assign pp[1] = a[0] & b[1];
      assign pp[2] = a[1] & b[1];

      assign result[0] = a[0] & b[0];
      assign result[1] = pp[0] ^ pp[1];      // first half adder.
      assign carry     = pp[0] & pp[1];
      assign result[2] = pp[2] ^ carry;      // second half adder.
      assign result[3] = pp[2] & carry;

    end else begin : g_split

      // ***********************************************************************
      // vertical and crosswise step over four half-width products
      // ***********************************************************************

      localparam int HALF = WIDTH / 2;

      logic [WIDTH-1:0]  q_ll;  // a low times b low.
      logic [WIDTH-1:0]  q_hl;  // a high times b low.
      logic [WIDTH-1:0]  q_lh;  // a low times b high.
      logic [WIDTH-1:0]  q_hh;  // a high times b high.
      logic [3*HALF-1:0] upper;

      vedic_core #(.WIDTH(HALF)) u_ll (.a(a[HALF-1:0]),     .b(b[HALF-1:0]),     .result(q_ll));
      vedic_core #(.WIDTH(HALF)) u_hl (.a(a[WIDTH-1:HALF]), .b(b[HALF-1:0]),     .result(q_hl));
      vedic_core #(.WIDTH(HALF)) u_lh (.a(a[HALF-1:0]),     .b(b[WIDTH-1:HALF]), .result(q_lh));
      vedic_core #(.WIDTH(HALF)) u_hh (.a(a[WIDTH-1:HALF]), .b(b[WIDTH-1:HALF]), .result(q_hh));

      // everything above the low HALF bits, in units of 2**HALF.
      // The exact product fits, so the sum cannot carry out of 3*HALF bits.
      assign upper = (3*HALF)'(q_ll[WIDTH-1:HALF])
                   + (3*HALF)'(q_hl)
                   + (3*HALF)'(q_lh)
                   + {q_hh, {HALF{1'b0}}};

      assign result = {upper, q_ll[HALF-1:0]};  // low half passes straight through.

    end
  endgenerate

endmodule

`default_nettype wire

// File: hdl/tap_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module tap_multiplier #(
  parameter int TAP_INDEX = 0
) (
  input  wire fir_types_pkg::sample_t sample,
  output fir_types_pkg::product_t     product
);

  localparam int SAMPLE_WIDTH  = fir_types_pkg::SAMPLE_WIDTH;
  localparam int PRODUCT_WIDTH = fir_types_pkg::PRODUCT_WIDTH;

  localparam fir_types_pkg::sample_t COEFF = fir_coeff_pkg::COEFFS[TAP_INDEX];

  // magnitude of the constant, worked out at elaboration.
  localparam logic [SAMPLE_WIDTH-1:0] COEFF_MAG =
    COEFF[SAMPLE_WIDTH-1] ? SAMPLE_WIDTH'(-COEFF) : SAMPLE_WIDTH'(COEFF);

  logic [SAMPLE_WIDTH-1:0]  sample_mag;
  logic [PRODUCT_WIDTH-1:0] mag_product;
  logic                     negate;

  // ***************************************************************************
  // sign and magnitude around the unsigned core
  // ***************************************************************************

  // -32768 maps to 16'h8000, which is still the right unsigned magnitude.
  assign sample_mag = sample[SAMPLE_WIDTH-1] ? SAMPLE_WIDTH'(-sample) : SAMPLE_WIDTH'(sample);

  assign negate = sample[SAMPLE_WIDTH-1] ^ COEFF[SAMPLE_WIDTH-1];

  vedic_core #(
    .WIDTH(SAMPLE_WIDTH)
  ) u_vedic_core (
    .a      (sample_mag),
    .b      (COEFF_MAG),
    .result (mag_product)
  );

  // the magnitude is below 2**31 for every table entry, so the negation is exact.
  assign product = negate ? fir_types_pkg::product_t'(-mag_product)
                          : fir_types_pkg::product_t'(mag_product);

endmodule

`default_nettype wire

// File: hdl/tap_sum_register.sv
`timescale 1ns/1ns
`default_nettype none

module tap_sum_register (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              clk_enable,
  input  wire fir_coeff_pkg::product_vector_t products,
  output fir_types_pkg::sum_t              filter_out
);

  localparam int NUM_TAPS = fir_coeff_pkg::NUM_TAPS;

  fir_types_pkg::sum_t sum_next;

  // ***************************************************************************
  // full precision adder tree
  // ***************************************************************************

  always_comb begin
    sum_next = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      sum_next = sum_next + fir_types_pkg::sum_t'(products[k]);  // sign extends.
    end
  end

  // ***************************************************************************
  // output register
  // ***************************************************************************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      filter_out <= '0;
    end else if (clk_enable) begin
      filter_out <= sum_next;
    end
  end

  // the output holds across any stretch of disabled edges.
  filter_out_hold_a : assert property (
    @(posedge clk) disable iff (reset)
    !clk_enable |=> $stable(filter_out)
  );

endmodule

`default_nettype wire

// File: hdl/fir_vedic_top.sv
`timescale 1ns/1ns
`default_nettype none

module fir_vedic_top (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         clk_enable,
  input  wire fir_types_pkg::sample_t filter_in,
  output fir_types_pkg::sum_t         filter_out
);

  localparam int NUM_TAPS = fir_coeff_pkg::NUM_TAPS;

  wire fir_coeff_pkg::tap_vector_t     taps;
  wire fir_coeff_pkg::product_vector_t products;

  // ***************************************************************************
  // delay line, one multiplier per tap, sum and output register
  // ***************************************************************************

  tap_delay_line u_delay_line (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .taps       (taps)
  );

  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    tap_multiplier #(
      .TAP_INDEX(k)
    ) u_tap_multiplier (
      .sample  (taps[k]),
      .product (products[k])
    );
  end

  // products are combinational, so the output lags the input by one enabled edge.
  tap_sum_register u_sum_register (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .products   (products),
    .filter_out (filter_out)
  );

endmodule

`default_nettype wire

// File: tests/fir_vedic_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fir_vedic_tb;

  localparam int NUM_TAPS       = 8;
  localparam int RESET_CYCLES   = 16;
  localparam int IMPULSE_CYCLES = 13;
  localparam int RANDOM_CYCLES  = 300;
  localparam int ENABLE_CYCLES  = 200;
  localparam int EXTREME_CYCLES = 40;
  localparam int MIDRUN_CYCLES  = 84;
  localparam int CYCLE_LIMIT    = RESET_CYCLES + IMPULSE_CYCLES + RANDOM_CYCLES
                                + ENABLE_CYCLES + EXTREME_CYCLES + MIDRUN_CYCLES + 100;

  logic                   clk;
  logic                   reset;
  logic                   clk_enable;
  fir_types_pkg::sample_t filter_in;
  fir_types_pkg::sum_t    filter_out;

  // tap 0 first, matching the newest sample.
  int coeff_model [NUM_TAPS] = '{-8773, -5490, 13275, 26632, 26632, 13275, -5490, -8773};

  fir_types_pkg::sample_t model_taps [NUM_TAPS];
  fir_types_pkg::sum_t    exp_out;
  logic [31:0]            lcg_state = 32'h1b06_74b8;
  int                     error_count = 0;
  int                     check_count = 0;
  int                     cycle_count = 0;

  fir_vedic_top u_fir_vedic_top (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d clock cycles without finishing", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ***************************************************************************
  // random numbers and the reference model
  // ***************************************************************************

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic fir_types_pkg::sample_t random_sample();
    logic [31:0] word;
    word = lcg_next();
    return word[31:16];  // the upper bits of an lcg are the most random.
  endfunction

  task automatic clear_model();
    exp_out = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      model_taps[k] = '0;
    end
  endtask

  // called at the rising edge, with the inputs that were set up before it.
  task automatic update_model();
    longint acc;
    acc = 0;
    if (reset) begin
      clear_model();
    end else if (clk_enable) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        acc += longint'(coeff_model[k]) * longint'(model_taps[k]);
      end
      exp_out = fir_types_pkg::sum_t'(acc);
      for (int k = NUM_TAPS - 1; k > 0; k--) begin
        model_taps[k] = model_taps[k-1];
      end
      model_taps[0] = filter_in;
    end
  endtask

  // ***************************************************************************
  // checks
  // ***************************************************************************

  task automatic check_sum(input string name, input fir_types_pkg::sum_t expected,
                           input fir_types_pkg::sum_t actual);
    check_count++;
    assert (actual === expected) else begin
      $display("Error at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic compare_outputs();
    check_sum("filter_out", exp_out, filter_out);
    for (int k = 0; k < NUM_TAPS; k++) begin
      check_count++;
      assert (u_fir_vedic_top.taps[k] === model_taps[k]) else begin
        $display("Error at %0t ns: taps[%0d] expected %0d, actual %0d",
                 $time, k, model_taps[k], u_fir_vedic_top.taps[k]);
        error_count++;
      end
    end
  endtask

  // inputs change 2 ns after an edge, outputs are compared 2 ns after the next.
  task automatic run_cycle(input fir_types_pkg::sample_t x, input logic en, input logic rst);
    reset      = rst;
    filter_in  = x;
    clk_enable = en;
    @(posedge clk);
    update_model();
    #2;
    compare_outputs();
  endtask

  // ***************************************************************************
  // test sequences
  // ***************************************************************************

  task automatic hold_reset(input int cycles);
    repeat (cycles) run_cycle('0, 1'b1, 1'b1);
  endtask

  task automatic send_impulse();
    fir_types_pkg::sum_t expected;
    for (int i = 0; i < IMPULSE_CYCLES; i++) begin
      run_cycle((i == 0) ? 16'sd1 : 16'sd0, 1'b1, 1'b0);
      expected = (i >= 1 && i <= NUM_TAPS) ? fir_types_pkg::sum_t'(coeff_model[i-1]) : '0;
      check_sum("filter_out", expected, filter_out);
    end
  endtask

  task automatic feed_random(input int cycles, input logic random_enable);
    fir_types_pkg::sample_t x;
    logic [31:0]            word;
    logic                   en;
    for (int i = 0; i < cycles; i++) begin
      x    = random_sample();
      word = lcg_next();
      en   = random_enable ? word[20] : 1'b1;
      run_cycle(x, en, 1'b0);
    end
  endtask

  task automatic push_extremes();
    fir_types_pkg::sample_t pattern [NUM_TAPS];
    for (int k = 0; k < NUM_TAPS; k++) begin
      pattern[k] = (coeff_model[k] > 0) ? 16'sh8000 : 16'sh7fff;  // every product negative.
    end
    repeat (12) run_cycle(16'sh8000, 1'b1, 1'b0);
    repeat (12) run_cycle(16'sh7fff, 1'b1, 1'b0);
    // oldest sample goes in first, so pattern[k] lands in tap k.
    for (int k = NUM_TAPS - 1; k >= 0; k--) begin
      run_cycle(pattern[k], 1'b1, 1'b0);
    end
    repeat (8) run_cycle('0, 1'b1, 1'b0);  // sum peaks below -2**31 on the first of these.
  endtask

  task automatic reset_mid_run();
    feed_random(40, 1'b1);
    repeat (4) run_cycle(random_sample(), 1'b1, 1'b1);
    feed_random(40, 1'b1);
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    clk_enable = 1'b0;
    filter_in  = '0;
    clear_model();
    hold_reset(RESET_CYCLES);
    send_impulse();
    feed_random(RANDOM_CYCLES, 1'b0);
    feed_random(ENABLE_CYCLES, 1'b1);
    push_extremes();
    reset_mid_run();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/fir_types_pkg.sv
hdl/fir_coeff_pkg.sv
hdl/tap_delay_line.sv
hdl/vedic_core.sv
hdl/tap_multiplier.sv
hdl/tap_sum_register.sv
hdl/fir_vedic_top.sv
tests/fir_vedic_tb.sv

// File: Makefile
# Verilator build for the Vedic FIR filter testbench.
# Any variable below can be overridden, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= fir_vedic_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= NO ERRORS

SOURCES := $(wildcard hdl/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
